/* Makefile */
# Verilator flow for the cartridge loader testbench

SIM = obj_dir/sim_cart

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_cart_loader -Mdir obj_dir -o sim_cart -f tb.f

run: compile
	./$(SIM) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/tb_cart_tests.svh */
// Directed tests for the cartridge loading path
// Included into the testbench top, built on its drivers and compare tasks
`ifndef TB_CART_TESTS_SVH
`define TB_CART_TESTS_SVH

	task automatic test_reset_values();
		check_bit("host_wait", 1'b0, host_wait);
		check_bit("region_set", 1'b0, region_set);
		check_quirks("quirks", '0, quirks);
		check_byte("gun_delay", cart_pkg::GUN_DELAY_DEFAULT, gun_delay);
	endtask

	// Burst of ROM words, data pattern from the whole address
	task automatic test_rom_writes();
		cart_pkg::addr_t a;
		start_download();
		for (int i = 0; i < 24; i++) begin
			a = 25'h10000 + 25'(2 * i);
			write_word(a, a[15:0] ^ {7'h2B, a[24:16]}, 0);
		end
		end_download();
	endtask

	//////////////////////////////
	// Region selection
	//////////////////////////////

	// Flags as {E, U, J}, first entry of the order is also the fallback
	function automatic cart_pkg::region_t pick_region(input cart_pkg::prio_t p,
			input logic [2:0] f);
		logic [5:0] order;
		case (p)
			2'd0: order = {cart_pkg::REGION_US, cart_pkg::REGION_EU, cart_pkg::REGION_JP};
			2'd1: order = {cart_pkg::REGION_EU, cart_pkg::REGION_US, cart_pkg::REGION_JP};
			2'd2: order = {cart_pkg::REGION_US, cart_pkg::REGION_JP, cart_pkg::REGION_EU};
			default: order = {cart_pkg::REGION_JP, cart_pkg::REGION_US, cart_pkg::REGION_EU};
		endcase
		if (f[order[5:4]])
			return order[5:4];
		if (f[order[3:2]])
			return order[3:2];
		if (f[order[1:0]])
			return order[1:0];
		return order[5:4];
	endfunction

	// One letter set under all four priority orders
	task automatic region_case(input cart_pkg::word_t w1f0, input cart_pkg::word_t w1f2,
			input logic [2:0] flags);
		auto_mode  = cart_pkg::AUTO_HEADER;
		host_index = 8'h00;
		for (int p = 0; p < 4; p++) begin
			prio = cart_pkg::prio_t'(p);
			start_download();
			write_word(cart_pkg::HDR_REGION_ADDR, w1f0, 0);
			write_word(cart_pkg::HDR_REGION2_ADDR, w1f2, 0);
			write_word(cart_pkg::HDR_END_ADDR, 16'h0000, 4);
			check_bit("region_set", 1'b0, set_c2);
			check_bit("region_set", 1'b1, set_c3);   // Three cycles after the write
			check_region("region_req", pick_region(prio, flags), req_c3);
			end_download();
		end
	endtask

	task automatic test_header_region();
		region_case(16'h4555, 16'h2020, 3'b110);    // U then E
		region_case(16'h2020, 16'h204A, 3'b001);    // J in the second word
		region_case(16'h2020, 16'h2020, 3'b000);
		region_case(16'h2035, 16'h2020, 3'b011);    // Digit 5
		region_case(16'h2041, 16'h2020, 3'b100);    // Digit A
	endtask

	task automatic ext_case(input logic [7:0] index);
		auto_mode  = cart_pkg::AUTO_FILE_EXT;
		host_index = index;
		start_download();
		write_word(cart_pkg::HDR_REGION_ADDR, 16'h4A55, 0);   // Letters ignored here
		write_word(cart_pkg::HDR_END_ADDR, 16'h0000, 4);
		check_region("region_req", index[7:6], req_c3);
		check_bit("region_set", index != 8'h00, set_c3);
		end_download();
	endtask

	task automatic off_case(input cart_pkg::auto_mode_t mode);
		auto_mode  = mode;
		host_index = 8'hC1;
		start_download();
		write_word(cart_pkg::HDR_REGION_ADDR, 16'h4555, 0);
		write_word(cart_pkg::HDR_END_ADDR, 16'h0000, 4);
		check_bit("region_set", 1'b0, set_c3);
		check_bit("region_set", 1'b0, set_c4);
		end_download();
	endtask

	task automatic test_ext_and_off();
		ext_case(8'h00);
		ext_case(8'h41);
		ext_case(8'h82);
		ext_case(8'hC7);
		off_case(cart_pkg::AUTO_OFF);
		off_case(2'd3);
	endtask

	//////////////////////////////
	// Serial lookup
	//////////////////////////////

	// Eight characters over five words, middle words low byte first
	task automatic write_serial(input logic [63:0] s);
		write_word(cart_pkg::ID_ADDR_FIRST, {s[63:56], 8'h20}, 0);
		write_word(cart_pkg::ID_ADDR_FIRST + 25'd2, {s[47:40], s[55:48]}, 0);
		write_word(cart_pkg::ID_ADDR_FIRST + 25'd4, {s[31:24], s[39:32]}, 0);
		write_word(cart_pkg::ID_ADDR_FIRST + 25'd6, {s[15:8], s[23:16]}, 0);
		write_word(cart_pkg::ID_ADDR_LAST, {8'h20, s[7:0]}, 0);
	endtask

	task automatic serial_case(input logic [63:0] serial, input cart_pkg::quirk_vec_t exp_q,
			input logic exp_type, input logic [7:0] exp_delay);
		start_download();
		write_serial(serial);
		write_word(cart_pkg::ID_LOOKUP_ADDR, 16'h2020, 4);
		check_quirks("quirks", '0, quirks_c1);
		check_quirks("quirks", exp_q, quirks_c2);
		check_bit("gun_type", exp_type, gun_type_c2);
		check_byte("gun_delay", exp_delay, gun_delay_c2);
		end_download();
	endtask

	task automatic test_quirk_lookup();
		serial_case("MK-1229 ", 9'd1 << cart_pkg::Q_SVP, 1'b0, cart_pkg::GUN_DELAY_DEFAULT);
		serial_case("T-12046 ", 9'd1 << cart_pkg::Q_EEPROM, 1'b0, cart_pkg::GUN_DELAY_DEFAULT);
		serial_case("T-95136-", '0, 1'b1, 8'd30);   // Lethal Enforcers II
		serial_case("XX-00000", '0, 1'b0, cart_pkg::GUN_DELAY_DEFAULT);
	endtask

	task automatic test_new_download_clears();
		serial_case("G-7001  ", 9'd1 << cart_pkg::Q_SVP, 1'b0, cart_pkg::GUN_DELAY_DEFAULT);
		host_download = 1'b1;
		next_cycle();
		check_quirks("quirks", 9'd1 << cart_pkg::Q_SVP, quirks);   // Start pulse only now
		next_cycle();
		check_quirks("quirks", '0, quirks);
		end_download();
	endtask

`endif

/* dv/tb_cart_loader.sv */
// Testbench for the cartridge loading path
// Memory acknowledge model with LFSR delays, compare tasks and watchdog
`default_nettype none

module tb_cart_loader;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 4000;   // Tests need roughly 600 cycles

	logic                 clk_sys = 1'b0;
	logic                 RESET;
	logic                 host_download, host_wr, host_wait;
	cart_pkg::addr_t      host_addr, rom_size;
	cart_pkg::word_t      host_data, rom_wdata;
	logic [7:0]           host_index, gun_delay;
	cart_pkg::auto_mode_t auto_mode;
	cart_pkg::prio_t      prio;
	logic                 rom_wr, rom_wr_ack, region_set, gun_type;
	logic [23:0]          rom_addr;
	cart_pkg::region_t    region_req;
	cart_pkg::quirk_vec_t quirks;

	int              err_value = 0;
	int              err_other = 0;
	int              cycle_count = 0;
	logic [1:0]      mem_delay;
	logic [3:0]      delay_seen = 4'b0000;
	logic [15:0]     lfsr = 16'd2;
	logic            exp_rom_wr = 1'b0;
	cart_pkg::addr_t last_addr;

	// Outputs seen one to four cycles after a write
	cart_pkg::quirk_vec_t quirks_c1, quirks_c2;
	logic                 gun_type_c2, set_c2, set_c3, set_c4;
	logic [7:0]           gun_delay_c2;
	cart_pkg::region_t    req_c3;

	always #20 clk_sys = ~clk_sys;

	cart_loader_top i_dut (.*);

	//////////////////////////////
	// Random delays and memory
	//////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_delay(output logic [1:0] d);
		d = 2'd0;
		repeat (2) begin
			lfsr = lfsr_next(lfsr);
			d = {d[0], lfsr[0]};
		end
	endtask

	// Answers each rom_wr toggle after 0 to 3 cycles
	initial begin : mem_model
		rom_wr_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#2;
			if (RESET)
				rom_wr_ack = 1'b0;
			else if (rom_wr !== rom_wr_ack) begin
				draw_delay(mem_delay);
				delay_seen[mem_delay] = 1'b1;
				repeat (mem_delay) begin
					@(posedge clk_sys);
					#2;
				end
				rom_wr_ack = rom_wr;
			end
		end
	end

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_value = err_value + 1;
			$display("ERR t=%0d ns %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic check_region(input string name, input cart_pkg::region_t exp,
			input cart_pkg::region_t act);
		if (act !== exp) begin
			err_value = err_value + 1;
			$display("ERR t=%0d ns %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_quirks(input string name, input cart_pkg::quirk_vec_t exp,
			input cart_pkg::quirk_vec_t act);
		if (act !== exp) begin
			err_value = err_value + 1;
			$display("ERR t=%0d ns %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input cart_pkg::word_t exp,
			input cart_pkg::word_t act);
		if (act !== exp) begin
			err_value = err_value + 1;
			$display("ERR t=%0d ns %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input cart_pkg::addr_t exp,
			input cart_pkg::addr_t act);
		if (act !== exp) begin
			err_value = err_value + 1;
			$display("ERR t=%0d ns %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			err_value = err_value + 1;
			$display("ERR t=%0d ns %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			err_value = err_value + 1;
			$display("ERR t=%0d ns %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	//////////////////////////////
	// Host side drivers
	//////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic start_download();
		host_download = 1'b1;
		next_cycle();
		next_cycle();                   // Start pulse has cleared the stages
	endtask

	task automatic end_download();
		host_download = 1'b0;
		next_cycle();
		check_addr("rom_size", last_addr, rom_size);
		next_cycle();
		check_bit("region_set", 1'b0, region_set);
	endtask

	// One host word, checked at the memory toggle and held until the answer
	task automatic write_word(input cart_pkg::addr_t addr, input cart_pkg::word_t data,
			input int watch);
		int k;
		int waited;
		host_wr   = 1'b1;
		host_addr = addr;
		host_data = data;
		last_addr = addr;
		next_cycle();
		host_wr    = 1'b0;
		exp_rom_wr = ~exp_rom_wr;
		check_bit("rom_wr", exp_rom_wr, rom_wr);
		check_addr("rom_addr", addr >> 1, {1'b0, rom_addr});
		check_word("rom_wdata", {data[7:0], data[15:8]}, rom_wdata);
		k = 1;
		waited = 0;
		while (host_wait || k <= watch) begin
			case (k)
				1: quirks_c1 = quirks;
				2: begin
					quirks_c2    = quirks;
					gun_type_c2  = gun_type;
					gun_delay_c2 = gun_delay;
					set_c2       = region_set;
				end
				3: begin
					set_c3 = region_set;
					req_c3 = region_req;
				end
				4: set_c4 = region_set;
				default: ;
			endcase
			if (host_wait) begin
				waited = waited + 1;
				check_bit("rom_wr", exp_rom_wr, rom_wr);   // No second toggle
			end
			if (waited > 8) begin
				err_other = err_other + 1;
				$display("host_wait was never released after the write to %h", addr);
				break;
			end
			next_cycle();
			k = k + 1;
		end
		check_count("host_wait cycles", int'(mem_delay) + 1, waited);
		check_bit("rom_wr_ack", exp_rom_wr, rom_wr_ack);
	endtask

	`include "tb_cart_tests.svh"

	//////////////////////////////
	// Sequence and watchdog
	//////////////////////////////

	initial begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		RESET         = 1'b1;
		host_download = 1'b0;
		host_wr       = 1'b0;
		host_addr     = '0;
		host_data     = '0;
		host_index    = 8'h00;
		auto_mode     = cart_pkg::AUTO_HEADER;
		prio          = 2'd0;
		last_addr     = '0;
		repeat (3) @(posedge clk_sys);
		#2;
		RESET = 1'b0;
		next_cycle();
		test_reset_values();
		test_rom_writes();
		test_header_region();
		test_ext_and_off();
		test_quirk_lookup();
		test_new_download_clears();
		if (delay_seen != 4'b1111) begin
			err_other = err_other + 1;
			$display("Memory model did not use every delay, seen mask %b", delay_seen);
		end
		$display("Done: %0d value errors, %0d other errors", err_value, err_other);
		if (err_value == 0 && err_other == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* source/cart_id_quirks.sv */
// Cartridge serial lookup
// Builds the header serial number and matches it against the title table
// for compatibility flags and light-gun settings
`default_nettype none

module cart_id_quirks (
	input  wire                   clk_sys,
	input  wire                   RESET,
	input  wire                   w_valid,
	input  wire cart_pkg::addr_t  w_addr,
	input  wire cart_pkg::word_t  w_data,
	input  wire                   load_start,
	output cart_pkg::quirk_vec_t  quirks,
	output logic                  gun_type,
	output logic [7:0]            gun_delay
);

	logic [63:0]          cart_id;      // Eight ASCII characters
	cart_pkg::quirk_vec_t id_hit;
	logic                 id_gun_type;
	logic [7:0]           id_gun_delay;
	logic                 lookup;

	assign lookup = w_valid && (w_addr == cart_pkg::ID_LOOKUP_ADDR);

	//////////////////////////////
	// Serial assembly
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (w_valid) begin
			if (w_addr == cart_pkg::ID_ADDR_FIRST)
				cart_id[63:56] <= w_data[15:8];
			if (w_addr == cart_pkg::ID_ADDR_FIRST + 25'd2)
				cart_id[55:40] <= {w_data[7:0], w_data[15:8]};
			if (w_addr == cart_pkg::ID_ADDR_FIRST + 25'd4)
				cart_id[39:24] <= {w_data[7:0], w_data[15:8]};
			if (w_addr == cart_pkg::ID_ADDR_FIRST + 25'd6)
				cart_id[23:8] <= {w_data[7:0], w_data[15:8]};
			if (w_addr == cart_pkg::ID_ADDR_LAST)
				cart_id[7:0] <= w_data[7:0];   // Low byte only
		end
	end

	//////////////////////////////
	// Title table
	//////////////////////////////

	always_comb begin
		id_hit = '0;
		case (cart_id)
			// Battery RAM mapping
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				id_hit[cart_pkg::Q_SRAM] = 1'b1;
			// Serial EEPROM saves
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				id_hit[cart_pkg::Q_EEPROM] = 1'b1;
			"T-113016": id_hit[cart_pkg::Q_NORAM]  = 1'b1;
			"T-89016 ": id_hit[cart_pkg::Q_FIFO]   = 1'b1;
			"T-574023", "T-574013":
				id_hit[cart_pkg::Q_PIER] = 1'b1;
			"MK-1229 ", "G-7001  ":
				id_hit[cart_pkg::Q_SVP] = 1'b1;
			// FM status busy bit relied on
			"T-35036 ", "T-25073 ", "MK-1137-":
				id_hit[cart_pkg::Q_FMBUSY] = 1'b1;
			"T-68???-": id_hit[cart_pkg::Q_SCHAN]  = 1'b1;   // '?' is literal
			" GM 0000": id_hit[cart_pkg::Q_SRAM00] = 1'b1;
			default: id_hit = '0;
		endcase
	end

	// Gun type and sensor offset per title
	always_comb begin
		case (cart_id)
			"MK-1533 ": begin
				id_gun_type  = 1'b0;
				id_gun_delay = 8'd100;
			end
			"T-95096-": begin
				id_gun_type  = 1'b1;
				id_gun_delay = 8'd52;
			end
			"T-95136-": begin
				id_gun_type  = 1'b1;
				id_gun_delay = 8'd30;
			end
			"MK-1658 ": begin
				id_gun_type  = 1'b0;
				id_gun_delay = 8'd120;
			end
			"T-081156": begin
				id_gun_type  = 1'b0;
				id_gun_delay = 8'd126;
			end
			default: begin
				id_gun_type  = 1'b0;
				id_gun_delay = cart_pkg::GUN_DELAY_DEFAULT;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks    <= '0;
			gun_type  <= 1'b0;
			gun_delay <= cart_pkg::GUN_DELAY_DEFAULT;
		end else begin
			if (load_start)
				quirks <= '0;           // Fresh cartridge
			if (lookup) begin
				quirks    <= quirks | id_hit;
				gun_type  <= id_gun_type;
				gun_delay <= id_gun_delay;
			end
		end
	end

	// One lookup per download leaves at most one flag
	a_single_quirk: assert property (
		@(posedge clk_sys) disable iff (RESET)
		$onehot0(quirks)
	);

endmodule

`default_nettype wire

/* source/cart_loader_top.sv */
// Cartridge loading path
// Host word stream into ROM memory, plus region and per-title decode
`default_nettype none

module cart_loader_top (
	input  wire                        clk_sys,
	input  wire                        RESET,
	// Host download port
	input  wire                        host_download,
	input  wire                        host_wr,
	input  wire cart_pkg::addr_t       host_addr,
	input  wire cart_pkg::word_t       host_data,
	input  wire [7:0]                  host_index,
	output logic                       host_wait,
	input  wire cart_pkg::auto_mode_t  auto_mode,
	input  wire cart_pkg::prio_t       prio,
	// ROM memory write port
	output logic                       rom_wr,
	input  wire                        rom_wr_ack,
	output logic [23:0]                rom_addr,
	output cart_pkg::word_t            rom_wdata,
	output cart_pkg::addr_t            rom_size,
	// Decoded cartridge settings
	output cart_pkg::region_t          region_req,
	output logic                       region_set,
	output cart_pkg::quirk_vec_t       quirks,
	output logic                       gun_type,
	output logic [7:0]                 gun_delay
);

	logic            w_valid;
	cart_pkg::addr_t w_addr;
	cart_pkg::word_t w_data;
	logic            load_start;
	logic            load_end;

	download_front u_front (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.host_download (host_download),
		.host_wr       (host_wr),
		.host_addr     (host_addr),
		.host_data     (host_data),
		.host_wait     (host_wait),
		.rom_wr        (rom_wr),
		.rom_wr_ack    (rom_wr_ack),
		.rom_addr      (rom_addr),
		.rom_wdata     (rom_wdata),
		.rom_size      (rom_size),
		.w_valid       (w_valid),
		.w_addr        (w_addr),
		.w_data        (w_data),
		.load_start    (load_start),
		.load_end      (load_end),
		.load_active   ()               // Later stages work from the edge pulses
	);

	region_decode u_region (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.w_valid    (w_valid),
		.w_addr     (w_addr),
		.w_data     (w_data),
		.load_start (load_start),
		.load_end   (load_end),
		.host_index (host_index),
		.auto_mode  (auto_mode),
		.prio       (prio),
		.region_req (region_req),
		.region_set (region_set)
	);

	cart_id_quirks u_quirks (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.w_valid    (w_valid),
		.w_addr     (w_addr),
		.w_data     (w_data),
		.load_start (load_start),
		.quirks     (quirks),
		.gun_type   (gun_type),
		.gun_delay  (gun_delay)
	);

endmodule

`default_nettype wire

/* source/cart_pkg.sv */
// Cartridge loader shared definitions
// Region codes, header word addresses, quirk flag positions and gun defaults
`default_nettype none

package cart_pkg;

	//////////////////////////////
	// Host stream types
	//////////////////////////////

	typedef logic [15:0] word_t;        // One host data word
	typedef logic [24:0] addr_t;        // Host byte address

	//////////////////////////////
	// Region selection
	//////////////////////////////

	typedef logic [1:0] region_t;
	typedef logic [1:0] auto_mode_t;
	typedef logic [1:0] prio_t;         // 0 US>EU>JP, 1 EU>US>JP, 2 US>JP>EU, 3 JP>US>EU

	localparam region_t REGION_JP = 2'd0;
	localparam region_t REGION_US = 2'd1;
	localparam region_t REGION_EU = 2'd2;

	// Automatic region source, code 3 behaves as off
	localparam auto_mode_t AUTO_HEADER   = 2'd0;
	localparam auto_mode_t AUTO_FILE_EXT = 2'd1;
	localparam auto_mode_t AUTO_OFF      = 2'd2;

	//////////////////////////////
	// Per-title quirks
	//////////////////////////////

	typedef logic [8:0] quirk_vec_t;

	localparam int Q_SRAM   = 0;
	localparam int Q_SRAM00 = 1;
	localparam int Q_EEPROM = 2;
	localparam int Q_NORAM  = 3;
	localparam int Q_FIFO   = 4;
	localparam int Q_PIER   = 5;
	localparam int Q_SVP    = 6;        // Cartridge carries the DSP
	localparam int Q_FMBUSY = 7;
	localparam int Q_SCHAN  = 8;

	//////////////////////////////
	// Header layout
	//////////////////////////////

	localparam addr_t HDR_REGION_ADDR  = 25'h1F0;   // Two region letters
	localparam addr_t HDR_REGION2_ADDR = 25'h1F2;   // Third region letter
	localparam addr_t HDR_END_ADDR     = 25'h200;   // Header fully received

	// Serial number spans five words
	localparam addr_t ID_ADDR_FIRST  = 25'h182;
	localparam addr_t ID_ADDR_LAST   = 25'h18A;
	localparam addr_t ID_LOOKUP_ADDR = 25'h18C;

	localparam logic [7:0] GUN_DELAY_DEFAULT = 8'd44;

endpackage

`default_nettype wire

/* source/download_front.sv */
// Download front end
// Registers host words, forwards them to ROM over the toggle handshake,
// holds the host off until the memory answers and latches the ROM size
`default_nettype none

module download_front (
	input  wire                   clk_sys,
	input  wire                   RESET,
	input  wire                   host_download,
	input  wire                   host_wr,
	input  wire cart_pkg::addr_t  host_addr,
	input  wire cart_pkg::word_t  host_data,
	output logic                  host_wait,
	output logic                  rom_wr,
	input  wire                   rom_wr_ack,
	output logic [23:0]           rom_addr,
	output cart_pkg::word_t       rom_wdata,
	output cart_pkg::addr_t       rom_size,
	output logic                  w_valid,
	output cart_pkg::addr_t       w_addr,
	output cart_pkg::word_t       w_data,
	output logic                  load_start,
	output logic                  load_end,
	output logic                  load_active
);

	logic host_we;

	assign host_we = host_download & host_wr;

	//////////////////////////////
	// Handshake and download edges
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			host_wait   <= 1'b0;
			rom_wr      <= 1'b0;
			w_valid     <= 1'b0;
			load_active <= 1'b0;
			load_start  <= 1'b0;
			load_end    <= 1'b0;
		end else begin
			w_valid     <= host_we;
			load_active <= host_download;
			load_start  <= host_download & ~load_active;
			load_end    <= ~host_download & load_active;

			if (host_we) begin
				host_wait <= 1'b1;
				rom_wr    <= ~rom_wr;       // New request for the memory
			end else if (host_wait && (rom_wr == rom_wr_ack)) begin
				host_wait <= 1'b0;          // Memory has taken the word
			end
		end
	end

	// Word held for the memory and the header decoders
	always_ff @(posedge clk_sys) begin
		if (host_we) begin
			w_addr <= host_addr;
			w_data <= host_data;
		end
		// Host address still shows the last word when the level drops
		if (load_active && !host_download)
			rom_size <= host_addr;
	end

	// Word address and big-endian byte order toward memory
	assign rom_addr  = w_addr[24:1];
	assign rom_wdata = {w_data[7:0], w_data[15:8]};

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Host honours the wait level
	a_no_wr_during_wait: assert property (
		@(posedge clk_sys) disable iff (RESET)
		host_wait |-> !host_wr
	);

	// One request toggle per accepted word
	a_toggle_with_wait: assert property (
		@(posedge clk_sys) disable iff (RESET)
		$changed(rom_wr) |-> $rose(host_wait)
	);

endmodule

`default_nettype wire

/* source/region_decode.sv */
// Region decode
// Collects region letters from the cartridge header and requests a
// console region from the header, the file extension, or not at all
`default_nettype none

module region_decode (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        w_valid,
	input  wire cart_pkg::addr_t       w_addr,
	input  wire cart_pkg::word_t       w_data,
	input  wire                        load_start,
	input  wire                        load_end,
	input  wire [7:0]                  host_index,
	input  wire cart_pkg::auto_mode_t  auto_mode,
	input  wire cart_pkg::prio_t       prio,
	output cart_pkg::region_t          region_req,
	output logic                       region_set
);

	logic              hdr_j, hdr_u, hdr_e;
	logic              hdr_ready;
	logic              hdr_ready_q;
	logic [2:0]        cur_flags;       // {E, U, J}
	logic [2:0]        lo_flags;
	logic [3:0]        hex_val;
	cart_pkg::region_t hdr_region;

	// Region letter to {E, U, J}
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		logic [2:0] f;
		f = 3'b000;
		if (c == "J")
			f = 3'b001;
		else if (c == "U")
			f = 3'b010;
		else if (c == "E")
			f = 3'b100;
		return f;
	endfunction

	assign hex_val   = w_data[3:0] - 4'd7;      // 'A'..'F' to 10..15
	assign cur_flags = load_start ? 3'b000 : {hdr_e, hdr_u, hdr_j};

	// Low byte at the first region word, letter or hex bit mask
	always_comb begin
		lo_flags = cur_flags;
		if (|letter_flags(w_data[7:0]))
			lo_flags = cur_flags | letter_flags(w_data[7:0]);
		else if (w_data[7:0] >= "0" && w_data[7:0] <= "9")
			lo_flags = {w_data[3], w_data[2], w_data[0]};
		else if (w_data[7:0] >= "A" && w_data[7:0] <= "F")
			lo_flags = {hex_val[3], hex_val[2], hex_val[0]};
	end

	//////////////////////////////
	// Priority tables
	//////////////////////////////

	always_comb begin
		case (prio)
			2'd0: hdr_region = hdr_u ? cart_pkg::REGION_US :
				hdr_e ? cart_pkg::REGION_EU :
				hdr_j ? cart_pkg::REGION_JP : cart_pkg::REGION_US;
			2'd1: hdr_region = hdr_e ? cart_pkg::REGION_EU :
				hdr_u ? cart_pkg::REGION_US :
				hdr_j ? cart_pkg::REGION_JP : cart_pkg::REGION_EU;
			2'd2: hdr_region = hdr_u ? cart_pkg::REGION_US :
				hdr_j ? cart_pkg::REGION_JP :
				hdr_e ? cart_pkg::REGION_EU : cart_pkg::REGION_US;
			default: hdr_region = hdr_j ? cart_pkg::REGION_JP :   // JP first
				hdr_u ? cart_pkg::REGION_US :
				hdr_e ? cart_pkg::REGION_EU : cart_pkg::REGION_JP;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			{hdr_e, hdr_u, hdr_j} <= 3'b000;
			hdr_ready   <= 1'b0;
			hdr_ready_q <= 1'b0;
			region_req  <= cart_pkg::REGION_JP;
			region_set  <= 1'b0;
		end else begin
			hdr_ready_q <= hdr_ready;
			{hdr_e, hdr_u, hdr_j} <= cur_flags;
			if (w_valid) begin
				if (w_addr == cart_pkg::HDR_REGION_ADDR)
					{hdr_e, hdr_u, hdr_j} <= lo_flags | letter_flags(w_data[15:8]);
				if (w_addr == cart_pkg::HDR_REGION2_ADDR)
					{hdr_e, hdr_u, hdr_j} <= cur_flags | letter_flags(w_data[7:0]);
				if (w_addr == cart_pkg::HDR_END_ADDR)
					hdr_ready <= 1'b1;
			end

			// Decision once per header
			if (hdr_ready && !hdr_ready_q && (auto_mode < cart_pkg::AUTO_OFF)) begin
				if (auto_mode == cart_pkg::AUTO_HEADER) begin
					region_req <= hdr_region;
					region_set <= 1'b1;
				end else begin
					region_req <= host_index[7:6];  // Extension index carries region
					region_set <= |host_index;
				end
			end

			if (load_end) begin
				hdr_ready  <= 1'b0;
				region_set <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+dv
source/cart_pkg.sv
source/download_front.sv
source/region_decode.sv
source/cart_id_quirks.sv
source/cart_loader_top.sv
dv/tb_cart_loader.sv
